//--- risk_vectors.txt
// Records: idx_a(3) idx_b(3) month(2) idx_c(3) idx_d(3) day(2), data_no 00 to 07
// Queries: formula mode month day data_no off_a off_b off_c off_d exp_warn exp_complete
190320034B06400A
064096020C80FA01
3E85DC0544C4B014
7FE7FF01FFF00001
BB8BB80CBB8BB819
7FF7FF067FF7FF0F
2582BC0732038404
0000000100000001
0 1 C 1F 00 000 000 000 000 0 1
0 3 C 1F 00 000 000 000 000 3 0
2 0 C 1F 05 000 000 000 000 3 0
2 1 C 1F 06 000 000 000 000 0 1
1 1 C 1F 02 000 000 000 000 3 0
1 0 C 1F 02 000 000 000 000 0 1
1 3 C 1F 01 000 000 000 000 0 1
1 3 C 1F 06 000 000 000 000 3 0
3 1 C 1F 03 000 000 000 000 3 0
3 0 C 1F 03 000 000 000 000 0 1
4 0 C 1F 03 7FE 800 FFF 001 0 1
4 1 C 1F 03 7FF 7FF FFE 000 3 0
4 3 C 1F 07 001 001 001 001 0 1
2 3 C 18 04 000 000 000 000 1 0
0 0 3 0A 00 000 000 000 000 0 1
0 0 3 09 00 000 000 000 000 1 0

//--- build.f
+incdir+.
risk_pkg.sv
risk_ifs.sv
query_capture.sv
record_fetch.sv
sort4.sv
risk_eval.sv
risk_checker_top.sv
tb_risk_checker.sv

//--- run.sh
#!/bin/sh
# Build and run the risk checker testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f build.f --top-module tb_risk_checker -o sim_tb_risk_checker
if [ $? -ne 0 ]; then
    echo "Verilator build did not succeed"
    exit 1
fi

out=$(./obj_dir/sim_tb_risk_checker)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1

//--- tb_risk_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "risk_macros.svh"

module tb_risk_checker import risk_pkg::*; ();

    localparam int CLK_PERIOD  = 40;
    localparam int NUM_RECORDS = 8;
    localparam int NUM_QUERIES = 16;
    localparam int VEC_COLS    = 11;
    localparam int NUM_ROUNDS  = 3;
    localparam int VEC_WORDS   = NUM_RECORDS + NUM_QUERIES * VEC_COLS;

    logic      clk;
    logic      inf;
    logic      formula_valid;
    formula_e  formula;
    logic      mode_valid;
    mode_e     mode;
    logic      date_valid;
    month_t    month;
    day_t      day;
    logic      data_no_valid;
    data_no_t  data_no;
    logic      index_valid;
    index_t    index;
    logic      mem_req;
    data_no_t  mem_addr;
    logic      mem_ack;
    mem_word_t mem_data;
    logic      out_valid;
    warn_e     warn_msg;
    logic      complete;

    logic [`RISK_MEM_W-1:0] vec [0:VEC_WORDS-1];
    logic [31:0]            rng_state;
    data_no_t               exp_addr;
    int                     ack_mode;
    int                     tests_run;
    int                     errors;

    risk_checker_top u_risk_checker_top (
        .clk           (clk),
        .inf           (inf),
        .formula_valid (formula_valid),
        .formula       (formula),
        .mode_valid    (mode_valid),
        .mode          (mode),
        .date_valid    (date_valid),
        .month         (month),
        .day           (day),
        .data_no_valid (data_no_valid),
        .data_no       (data_no),
        .index_valid   (index_valid),
        .index         (index),
        .mem_req       (mem_req),
        .mem_addr      (mem_addr),
        .mem_ack       (mem_ack),
        .mem_data      (mem_data),
        .out_valid     (out_valid),
        .warn_msg      (warn_msg),
        .complete      (complete)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // ========================================
    // Memory model, four-phase handshake
    // ========================================
    initial begin
        int delay;
        mem_ack   = 1'b0;
        mem_data  = '0;
        rng_state = 32'h9f69_2cde;
        forever begin
            @(posedge clk);
            #2;
            if (mem_req && !mem_ack) begin
                case (ack_mode)
                    0: delay = 1;
                    1: begin
                        rng_state = xorshift32(rng_state);
                        delay     = int'(rng_state[2:0]) + 1;
                    end
                    default: delay = 8;
                endcase
                repeat (delay - 1) begin
                    @(posedge clk);
                    #2;
                end
                assert (mem_addr == exp_addr) else begin
                    $display("error at %0t: mem_addr %0d, expected %0d",
                             $time, mem_addr, exp_addr);
                    errors++;
                end
                mem_ack  = 1'b1;
                mem_data = vec[mem_addr[2:0]];
                // Ack stays up until the request is released
                while (mem_req) begin
                    @(posedge clk);
                    #2;
                end
                mem_ack = 1'b0;
            end
        end
    end

    // Fields first, then offsets A to D on four cycles
    task automatic drive_query(input int base);
        formula_valid = 1'b1;
        formula       = formula_e'(vec[base][2:0]);
        mode_valid    = 1'b1;
        mode          = mode_e'(vec[base+1][1:0]);
        date_valid    = 1'b1;
        month         = month_t'(vec[base+2][3:0]);
        day           = day_t'(vec[base+3][4:0]);
        data_no_valid = 1'b1;
        data_no       = data_no_t'(vec[base+4][`RISK_NO_W-1:0]);
        exp_addr      = data_no;
        @(posedge clk);
        #2;
        formula_valid = 1'b0;
        mode_valid    = 1'b0;
        date_valid    = 1'b0;
        data_no_valid = 1'b0;
        for (int k = 0; k < 4; k++) begin
            index_valid = 1'b1;
            index       = index_t'(vec[base+5+k][`RISK_INDEX_W-1:0]);
            @(posedge clk);
            #2;
        end
        index_valid = 1'b0;
    endtask

    task automatic run_query(input int round, input int qi);
        int    base;
        int    errors_before;
        warn_e exp_warn;
        logic  exp_complete;
        base          = NUM_RECORDS + qi * VEC_COLS;
        errors_before = errors;
        exp_warn      = warn_e'(vec[base+9][1:0]);
        exp_complete  = vec[base+10][0];
        drive_query(base);
        while (!out_valid) begin
            @(posedge clk);
            #2;
        end
        assert (warn_msg == exp_warn) else begin
            $display("error at %0t: round %0d query %0d warn_msg %0d, expected %0d",
                     $time, round, qi, warn_msg, exp_warn);
            errors++;
        end
        assert (complete == exp_complete) else begin
            $display("error at %0t: round %0d query %0d complete %0b, expected %0b",
                     $time, round, qi, complete, exp_complete);
            errors++;
        end
        @(posedge clk);
        #2;
        assert (!out_valid) else begin
            $display("error at %0t: round %0d query %0d out_valid high for two cycles",
                     $time, round, qi);
            errors++;
        end
        tests_run++;
        $display("round %0d query %0d formula %0d mode %0d: warn_msg %0d complete %0b %s",
                 round, qi, vec[base][2:0], vec[base+1][1:0], exp_warn, exp_complete,
                 (errors == errors_before) ? "ok" : "mismatch");
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        inf           = 1'b0;
        formula_valid = 1'b0;
        formula       = FORMULA_A;
        mode_valid    = 1'b0;
        mode          = MODE_INSENSITIVE;
        date_valid    = 1'b0;
        month         = '0;
        day           = '0;
        data_no_valid = 1'b0;
        data_no       = '0;
        index_valid   = 1'b0;
        index         = '0;
        exp_addr      = '0;
        ack_mode      = 0;
        tests_run     = 0;
        errors        = 0;
        $readmemh("risk_vectors.txt", vec);

        repeat (5) @(posedge clk);
        #2;
        inf = 1'b1;
        @(posedge clk);
        #2;
        assert (!out_valid && !complete && !mem_req && warn_msg == NO_WARN) else begin
            $display("error at %0t: outputs not idle after reset", $time);
            errors++;
        end
        tests_run++;
        $display("reset state: %s", (errors == 0) ? "ok" : "mismatch");

        // Fast memory, random latency, then ack after the last offset
        for (int round = 0; round < NUM_ROUNDS; round++) begin
            ack_mode = round;
            for (int qi = 0; qi < NUM_QUERIES; qi++) begin
                run_query(round, qi);
            end
        end

        $display("%0d tests run, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(NUM_ROUNDS * NUM_QUERIES * 60 * CLK_PERIOD);
        $display("Timeout: the DUT stopped answering before all queries were done");
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- risk_checker_top.sv
`timescale 1ns/1ps
`default_nettype none

module risk_checker_top import risk_pkg::*; (
    input  wire logic clk,
    input  wire logic inf,
    input  wire logic formula_valid,
    input  formula_e  formula,
    input  wire logic mode_valid,
    input  mode_e     mode,
    input  wire logic date_valid,
    input  month_t    month,
    input  day_t      day,
    input  wire logic data_no_valid,
    input  data_no_t  data_no,
    input  wire logic index_valid,
    input  index_t    index,
    output logic      mem_req,
    output data_no_t  mem_addr,
    input  wire logic mem_ack,
    input  mem_word_t mem_data,
    output logic      out_valid,
    output warn_e     warn_msg,
    output logic      complete
);

    query_if  u_query_if ();
    record_if u_record_if ();

    // Query capture and record fetch run side by side
    query_capture u_query_capture (
        .clk           (clk),
        .inf           (inf),
        .formula_valid (formula_valid),
        .formula       (formula),
        .mode_valid    (mode_valid),
        .mode          (mode),
        .date_valid    (date_valid),
        .month         (month),
        .day           (day),
        .index_valid   (index_valid),
        .index         (index),
        .q             (u_query_if.producer)
    );

    record_fetch u_record_fetch (
        .clk           (clk),
        .inf           (inf),
        .data_no_valid (data_no_valid),
        .data_no       (data_no),
        .mem_req       (mem_req),
        .mem_addr      (mem_addr),
        .mem_ack       (mem_ack),
        .mem_data      (mem_data),
        .r             (u_record_if.producer)
    );

    risk_eval u_risk_eval (
        .clk       (clk),
        .inf       (inf),
        .q         (u_query_if.consumer),
        .r         (u_record_if.consumer),
        .out_valid (out_valid),
        .warn_msg  (warn_msg),
        .complete  (complete)
    );

endmodule

`default_nettype wire

//--- risk_eval.sv
`timescale 1ns/1ps
`default_nettype none

`include "risk_macros.svh"

module risk_eval import risk_pkg::*; (
    input  wire logic     clk,
    input  wire logic     inf,
    query_if.consumer     q,
    record_if.consumer    r,
    output logic          out_valid,
    output warn_e         warn_msg,
    output logic          complete
);

    eval_state_e state, next_state;
    logic        start;
    logic        wait_cnt;

    formula_e formula_q;
    mode_e    mode_q;
    month_t   q_month, r_month;
    day_t     q_day, r_day;
    index_t   off_a_q, off_b_q, off_c_q, off_d_q;
    index_t   idx_a_q, idx_b_q, idx_c_q, idx_d_q;

    index_t                  sort_max, sort_min;
    logic [`RISK_INDEX_W+1:0] idx_sum;
    logic [2:0]              high_cnt, above_cnt;
    score_t                  formula_result, threshold;
    logic                    date_warn;
    warn_e                   warn_next;

    // ========================================
    // FSM
    // ========================================
    assign start   = (state == EVAL_IDLE) && q.ready && r.ready;
    assign q.taken = start;
    assign r.taken = start;

    always_comb begin
        case (state)
            EVAL_IDLE:   next_state = start ? EVAL_LATCH : EVAL_IDLE;
            EVAL_LATCH:  next_state = EVAL_WAIT;
            EVAL_WAIT:   next_state = wait_cnt ? EVAL_REPORT : EVAL_WAIT;
            EVAL_REPORT: next_state = EVAL_IDLE;
            default:     next_state = EVAL_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            state    <= EVAL_IDLE;
            wait_cnt <= 1'b0;
        end else begin
            state    <= next_state;
            wait_cnt <= (state == EVAL_WAIT) ? ~wait_cnt : 1'b0;
        end
    end

    // Operands are taken in the same cycle as the handshake
    always_ff @(posedge clk) begin
        if (start) begin
            formula_q <= q.formula;
            mode_q    <= q.mode;
            q_month   <= q.month;
            q_day     <= q.day;
            off_a_q   <= q.off_a;
            off_b_q   <= q.off_b;
            off_c_q   <= q.off_c;
            off_d_q   <= q.off_d;
            r_month   <= r.month;
            r_day     <= r.day;
            idx_a_q   <= r.idx_a;
            idx_b_q   <= r.idx_b;
            idx_c_q   <= r.idx_c;
            idx_d_q   <= r.idx_d;
        end
    end

    sort4 u_sort4 (
        .clk     (clk),
        .in_a    (idx_a_q),
        .in_b    (idx_b_q),
        .in_c    (idx_c_q),
        .in_d    (idx_d_q),
        .max_out (sort_max),
        .min_out (sort_min)
    );

    // ========================================
    // Formula datapath
    // ========================================
    assign idx_sum = {2'b00, idx_a_q} + {2'b00, idx_b_q} + {2'b00, idx_c_q} + {2'b00, idx_d_q};

    assign high_cnt = 3'(idx_a_q >= `RISK_HIGH_INDEX) + 3'(idx_b_q >= `RISK_HIGH_INDEX)
                    + 3'(idx_c_q >= `RISK_HIGH_INDEX) + 3'(idx_d_q >= `RISK_HIGH_INDEX);

    // Stored index against its own query offset
    assign above_cnt = 3'(idx_a_q >= off_a_q) + 3'(idx_b_q >= off_b_q)
                     + 3'(idx_c_q >= off_c_q) + 3'(idx_d_q >= off_d_q);

    always_comb begin
        case (formula_q)
            FORMULA_A: formula_result = idx_sum[`RISK_INDEX_W+1:2];
            FORMULA_B: formula_result = sort_max - sort_min;
            FORMULA_C: formula_result = sort_min;
            FORMULA_D: formula_result = score_t'(high_cnt);
            FORMULA_E: formula_result = score_t'(above_cnt);
            default:   formula_result = '0;
        endcase
    end

    // Threshold table
    always_comb begin
        case (formula_q)
            FORMULA_A, FORMULA_C: begin
                case (mode_q)
                    MODE_INSENSITIVE: threshold = `THR_LEVEL_INSENSITIVE;
                    MODE_NORMAL:      threshold = `THR_LEVEL_NORMAL;
                    default:          threshold = `THR_LEVEL_SENSITIVE;
                endcase
            end
            FORMULA_B: begin
                case (mode_q)
                    MODE_INSENSITIVE: threshold = `THR_SPREAD_INSENSITIVE;
                    MODE_NORMAL:      threshold = `THR_SPREAD_NORMAL;
                    default:          threshold = `THR_SPREAD_SENSITIVE;
                endcase
            end
            default: begin
                case (mode_q)
                    MODE_INSENSITIVE: threshold = `THR_COUNT_INSENSITIVE;
                    MODE_NORMAL:      threshold = `THR_COUNT_NORMAL;
                    default:          threshold = `THR_COUNT_SENSITIVE;
                endcase
            end
        endcase
    end

    // ========================================
    // Judge and report
    // ========================================
    assign date_warn = (q_month < r_month) || ((q_month == r_month) && (q_day < r_day));
    assign warn_next = date_warn ? DATE_WARN
                     : (formula_result >= threshold) ? RISK_WARN : NO_WARN;

    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            out_valid <= 1'b0;
            warn_msg  <= NO_WARN;
            complete  <= 1'b0;
        end else if (state == EVAL_REPORT) begin
            out_valid <= 1'b1;
            warn_msg  <= warn_next;
            complete  <= (warn_next == NO_WARN);
        end else begin
            out_valid <= 1'b0;
            warn_msg  <= NO_WARN;
            complete  <= 1'b0;
        end
    end

    a_single_pulse: assert property (
        @(posedge clk) disable iff (!inf) out_valid |=> !out_valid
    );

endmodule

`default_nettype wire

//--- sort4.sv
`timescale 1ns/1ps
`default_nettype none

module sort4 (
    input  wire logic        clk,
    input  risk_pkg::index_t in_a,
    input  risk_pkg::index_t in_b,
    input  risk_pkg::index_t in_c,
    input  risk_pkg::index_t in_d,
    output risk_pkg::index_t max_out,
    output risk_pkg::index_t min_out
);

    risk_pkg::index_t s1_a, s1_b, s1_c, s1_d;
    logic             s1_ab_gt, s1_cd_gt;
    risk_pkg::index_t s2_max0, s2_min0, s2_max1, s2_min1;

    // Stage 1 compares both pairs
    always_ff @(posedge clk) begin
        s1_a     <= in_a;
        s1_b     <= in_b;
        s1_c     <= in_c;
        s1_d     <= in_d;
        s1_ab_gt <= in_a > in_b;
        s1_cd_gt <= in_c > in_d;
    end

    // Stage 2 picks the pair winners
    always_ff @(posedge clk) begin
        s2_max0 <= s1_ab_gt ? s1_a : s1_b;
        s2_min0 <= s1_ab_gt ? s1_b : s1_a;
        s2_max1 <= s1_cd_gt ? s1_c : s1_d;
        s2_min1 <= s1_cd_gt ? s1_d : s1_c;
    end

    // Stage 3 settles overall max and min
    always_ff @(posedge clk) begin
        max_out <= (s2_max0 > s2_max1) ? s2_max0 : s2_max1;
        min_out <= (s2_min0 < s2_min1) ? s2_min0 : s2_min1;
    end

endmodule

`default_nettype wire

//--- record_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "risk_macros.svh"

module record_fetch import risk_pkg::*; (
    input  wire logic     clk,
    input  wire logic     inf,
    input  wire logic     data_no_valid,
    input  data_no_t      data_no,
    output logic          mem_req,
    output data_no_t      mem_addr,
    input  wire logic     mem_ack,
    input  mem_word_t     mem_data,
    record_if.producer    r
);

    typedef enum logic [1:0] {
        FETCH_IDLE    = 2'd0,
        FETCH_REQ     = 2'd1,
        FETCH_RELEASE = 2'd2
    } fetch_state_e;

    fetch_state_e state;
    logic         pend;
    mem_word_t    rec_word;

    // ========================================
    // Four-phase request FSM
    // ========================================
    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            state   <= FETCH_IDLE;
            mem_req <= 1'b0;
            pend    <= 1'b0;
        end else begin
            case (state)
                FETCH_IDLE: begin
                    if (data_no_valid || pend) begin
                        mem_req <= 1'b1;
                        pend    <= 1'b0;
                        state   <= FETCH_REQ;
                    end
                end
                FETCH_REQ: begin
                    if (mem_ack) begin
                        mem_req <= 1'b0;
                        state   <= FETCH_RELEASE;
                    end
                end
                FETCH_RELEASE: begin
                    // Hold a new number until the memory drops ack
                    if (data_no_valid) begin
                        pend <= 1'b1;
                    end
                    if (!mem_ack) begin
                        state <= FETCH_IDLE;
                    end
                end
                default: state <= FETCH_IDLE;
            endcase
        end
    end

    // Address only moves while no request is open
    always_ff @(posedge clk) begin
        if (data_no_valid && state != FETCH_REQ) begin
            mem_addr <= data_no;
        end
    end

    always_ff @(posedge clk) begin
        if (state == FETCH_REQ && mem_ack) begin
            rec_word <= mem_data;
        end
    end

    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            r.ready <= 1'b0;
        end else if (r.taken) begin
            r.ready <= 1'b0;
        end else if (state == FETCH_REQ && mem_ack) begin
            r.ready <= 1'b1;
        end
    end

    // ========================================
    // Record decode
    // ========================================
    assign r.idx_a = rec_word[`RISK_IDX_A_HI:`RISK_IDX_A_LO];
    assign r.idx_b = rec_word[`RISK_IDX_B_HI:`RISK_IDX_B_LO];
    assign r.idx_c = rec_word[`RISK_IDX_C_HI:`RISK_IDX_C_LO];
    assign r.idx_d = rec_word[`RISK_IDX_D_HI:`RISK_IDX_D_LO];
    assign r.month = month_t'(rec_word[`RISK_MONTH_HI:`RISK_MONTH_LO]);
    assign r.day   = day_t'(rec_word[`RISK_DAY_HI:`RISK_DAY_LO]);

    a_addr_stable: assert property (
        @(posedge clk) disable iff (!inf) (mem_req && $past(mem_req)) |-> $stable(mem_addr)
    );

    // Ack seen at the edge that raised the request must already be low
    a_req_after_ack_low: assert property (
        @(posedge clk) disable iff (!inf) $rose(mem_req) |-> !$past(mem_ack)
    );

endmodule

`default_nettype wire

//--- query_capture.sv
`timescale 1ns/1ps
`default_nettype none

module query_capture import risk_pkg::*; (
    input  wire logic     clk,
    input  wire logic     inf,
    input  wire logic     formula_valid,
    input  formula_e      formula,
    input  wire logic     mode_valid,
    input  mode_e         mode,
    input  wire logic     date_valid,
    input  month_t        month,
    input  day_t          day,
    input  wire logic     index_valid,
    input  index_t        index,
    query_if.producer     q
);

    logic [1:0] idx_cnt;

    // ========================================
    // Query fields
    // ========================================
    always_ff @(posedge clk) begin
        if (formula_valid) begin
            q.formula <= formula;
        end
        if (mode_valid) begin
            q.mode <= mode;
        end
        if (date_valid) begin
            q.month <= month;
            q.day   <= day;
        end
    end

    // Offsets arrive A first, so they shift down from D
    always_ff @(posedge clk) begin
        if (index_valid) begin
            q.off_d <= index;
            q.off_c <= q.off_d;
            q.off_b <= q.off_c;
            q.off_a <= q.off_b;
        end
    end

    // ========================================
    // Offset count and ready
    // ========================================
    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            idx_cnt <= 2'd0;
            q.ready <= 1'b0;
        end else if (q.taken) begin
            idx_cnt <= 2'd0;
            q.ready <= 1'b0;
        end else if (index_valid) begin
            idx_cnt <= idx_cnt + 2'd1;
            if (idx_cnt == 2'd3) begin
                q.ready <= 1'b1;
            end
        end
    end

    // A new offset must wait until the evaluator has taken the query
    a_no_index_while_ready: assert property (
        @(posedge clk) disable iff (!inf) q.ready |-> !index_valid
    );

endmodule

`default_nettype wire

//--- risk_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// Finished query from the capture block
interface query_if import risk_pkg::*; ();
    formula_e formula;
    mode_e    mode;
    month_t   month;
    day_t     day;
    index_t   off_a;
    index_t   off_b;
    index_t   off_c;
    index_t   off_d;
    logic     ready;
    logic     taken;

    modport producer (output formula, mode, month, day, off_a, off_b, off_c, off_d, ready,
                      input taken);
    modport consumer (input formula, mode, month, day, off_a, off_b, off_c, off_d, ready,
                      output taken);
endinterface

// Decoded record from the memory fetch
interface record_if import risk_pkg::*; ();
    month_t month;
    day_t   day;
    index_t idx_a;
    index_t idx_b;
    index_t idx_c;
    index_t idx_d;
    logic   ready;
    logic   taken;

    modport producer (output month, day, idx_a, idx_b, idx_c, idx_d, ready, input taken);
    modport consumer (input month, day, idx_a, idx_b, idx_c, idx_d, ready, output taken);
endinterface

`default_nettype wire

//--- risk_pkg.sv
`default_nettype none

`include "risk_macros.svh"

package risk_pkg;

    // ========================================
    // Vector types
    // ========================================
    typedef logic [`RISK_INDEX_W-1:0] index_t;
    typedef logic [3:0]               month_t;
    typedef logic [4:0]               day_t;
    typedef logic [`RISK_NO_W-1:0]    data_no_t;
    typedef logic [`RISK_MEM_W-1:0]   mem_word_t;
    typedef logic [`RISK_INDEX_W-1:0] score_t;

    // ========================================
    // Encodings
    // ========================================
    typedef enum logic [2:0] {
        FORMULA_A = 3'd0,
        FORMULA_B = 3'd1,
        FORMULA_C = 3'd2,
        FORMULA_D = 3'd3,
        FORMULA_E = 3'd4
    } formula_e;

    typedef enum logic [1:0] {
        MODE_INSENSITIVE = 2'b00,
        MODE_NORMAL      = 2'b01,
        MODE_SENSITIVE   = 2'b11
    } mode_e;

    typedef enum logic [1:0] {
        NO_WARN   = 2'b00,
        DATE_WARN = 2'b01,
        RISK_WARN = 2'b11
    } warn_e;

    // Evaluator states
    typedef enum logic [1:0] {
        EVAL_IDLE   = 2'd0,
        EVAL_LATCH  = 2'd1,
        EVAL_WAIT   = 2'd2,
        EVAL_REPORT = 2'd3
    } eval_state_e;

endpackage

`default_nettype wire

//--- risk_macros.svh
`ifndef RISK_MACROS_SVH
`define RISK_MACROS_SVH

// Basic widths
`define RISK_INDEX_W 12
`define RISK_MEM_W   64
`define RISK_NO_W    8

// Record word layout
`define RISK_IDX_A_HI 63
`define RISK_IDX_A_LO 52
`define RISK_IDX_B_HI 51
`define RISK_IDX_B_LO 40
`define RISK_MONTH_HI 39
`define RISK_MONTH_LO 32
`define RISK_IDX_C_HI 31
`define RISK_IDX_C_LO 20
`define RISK_IDX_D_HI 19
`define RISK_IDX_D_LO 8
`define RISK_DAY_HI   7
`define RISK_DAY_LO   0

// Index at or above this counts as high for formula D
`define RISK_HIGH_INDEX 12'd2047

// Thresholds per formula group and mode
`define THR_LEVEL_INSENSITIVE  12'd2047
`define THR_LEVEL_NORMAL       12'd1023
`define THR_LEVEL_SENSITIVE    12'd511
`define THR_SPREAD_INSENSITIVE 12'd800
`define THR_SPREAD_NORMAL      12'd400
`define THR_SPREAD_SENSITIVE   12'd200
`define THR_COUNT_INSENSITIVE  12'd3
`define THR_COUNT_NORMAL       12'd2
`define THR_COUNT_SENSITIVE    12'd1

`endif
